// File: dekoderPkg.sv
package dekoderPkg;

    localparam int wortBreite    = 32;
    localparam int regAdrBreite  = 6;    // Bit 5 selects the float bank
    localparam int speicherTiefe = 64;

    // Opcodes that need their own handling
    localparam logic [5:0] loadCode   = 6'b111000;
    localparam logic [5:0] loadSCode  = 6'b111001;
    localparam logic [5:0] storeCode  = 6'b111010;
    localparam logic [5:0] storeSCode = 6'b111011;
    localparam logic [5:0] jregCode   = 6'b111100;
    localparam logic [5:0] bezCode    = 6'b111101;
    localparam logic [5:0] bnezCode   = 6'b111110;
    localparam logic [5:0] jalCode    = 6'b111111;
    localparam logic [5:0] jmpCode    = 6'b010000;
    localparam logic [5:0] addisCode  = 6'b110000;

    // Top opcode bits
    localparam logic [1:0] registerFormat  = 2'b00;
    localparam logic [1:0] jumpFormat      = 2'b01;
    localparam logic       immediateFormat = 1'b1;

    // Function field bits 5:4
    localparam logic [1:0] arithmetik = 2'b00;
    localparam logic [1:0] vergleich  = 2'b01;
    localparam logic [1:0] gleitkomma = 2'b10;
    localparam logic [1:0] vektor     = 2'b11;

    localparam logic [regAdrBreite-1:0] linkRegister = 6'd31;

    typedef enum logic [1:0] {
        holen      = 2'b00,
        dekodieren = 2'b01,
        ausfuehren = 2'b10,
        ruhe       = 2'b11
    } ablaufZustand;

endpackage

// File: befehlsSpeicher.sv
`timescale 1ns/1ps

module befehlsSpeicher (
    input  logic                                       Reset,
    input  logic                                       ladeEnable,
    input  logic [$clog2(dekoderPkg::speicherTiefe)-1:0] ladeAdresse,
    input  logic [dekoderPkg::wortBreite-1:0]            ladeDaten,
    input  logic                                       holeStrobe,
    input  logic [$clog2(dekoderPkg::speicherTiefe)-1:0] befehlsAdresse,
    output logic [dekoderPkg::wortBreite-1:0]            befehl
);

    logic [dekoderPkg::wortBreite-1:0] speicher [dekoderPkg::speicherTiefe];

    // Loader port
    always_ff @(posedge Reset) begin
        if (ladeEnable) begin
            speicher[ladeAdresse] <= ladeDaten;
        end
    end

    // Word valid one cycle after the fetch pulse
    always_ff @(posedge Reset) begin
        if (holeStrobe) begin
            befehl <= speicher[befehlsAdresse];
        end
    end

endmodule

// File: instruktionsDekodierer.sv
`timescale 1ns/1ps

module instruktionsDekodierer (
    input  logic                                Reset,
    input  logic                                DekodierSignal,
    input  logic                                dekodierStrobe,
    input  logic [dekoderPkg::wortBreite-1:0]   Instruktion,
    output logic [dekoderPkg::regAdrBreite-1:0] QuellRegister1,
    output logic [dekoderPkg::regAdrBreite-1:0] QuellRegister2,
    output logic [dekoderPkg::regAdrBreite-1:0] ZielRegister,
    output logic [dekoderPkg::wortBreite-1:0]   IDaten,
    output logic                                ImmediateAktiv,
    output logic [5:0]                          FunktionsCode,
    output logic                                JALBefehl,
    output logic                                RelativerSprung,
    output logic                                LoadBefehl,
    output logic                                StoreBefehl,
    output logic                                UnbedingterSprungBefehl,
    output logic                                BedingterSprungBefehl,
    output logic                                AbsoluterSprung,
    output logic                                Sprungbedingung
);

    logic [dekoderPkg::wortBreite-1:0] aktuellerBefehl;

    logic [5:0]  opcode;
    logic [1:0]  format;
    logic [1:0]  kategorie;
    logic [4:0]  zRegister;
    logic [4:0]  q1Register;
    logic [4:0]  q2Register;
    logic [5:0]  funktion;
    logic [4:0]  funktionAnfang;
    logic [15:0] kleinerImmediate;
    logic [25:0] grosserImmediate;
    logic [3:0]  gleitkommaBefehl;
    logic        floatBank;

    always_ff @(posedge Reset or posedge DekodierSignal) begin
        if (DekodierSignal) begin
            aktuellerBefehl <= '0;
        end else if (dekodierStrobe) begin
            aktuellerBefehl <= Instruktion;
        end
    end

    assign opcode           = aktuellerBefehl[31:26];
    assign format           = aktuellerBefehl[31:30];
    assign kategorie        = aktuellerBefehl[5:4];
    assign zRegister        = aktuellerBefehl[25:21];
    assign q1Register       = aktuellerBefehl[20:16];
    assign q2Register       = aktuellerBefehl[15:11];
    assign funktion         = aktuellerBefehl[5:0];
    assign funktionAnfang   = aktuellerBefehl[30:26];
    assign kleinerImmediate = aktuellerBefehl[15:0];
    assign grosserImmediate = aktuellerBefehl[25:0];
    assign gleitkommaBefehl = aktuellerBefehl[3:0];

    // Float ops in register format live in the upper bank
    assign floatBank = (format == dekoderPkg::registerFormat)
                    && (kategorie == dekoderPkg::gleitkomma);

    assign QuellRegister1 = {floatBank, q1Register};

    // Stores read their data register from the target field
    assign QuellRegister2 = (opcode == dekoderPkg::storeCode)  ? {1'b0, zRegister} :
                            (opcode == dekoderPkg::storeSCode) ? {1'b1, zRegister} :
                            {floatBank, q2Register};

    assign ZielRegister =
        (opcode == dekoderPkg::loadSCode || opcode == dekoderPkg::storeSCode
            || (floatBank && gleitkommaBefehl < 4'd8)) ? {1'b1, zRegister} :
        (format == dekoderPkg::registerFormat
            || format[1] == dekoderPkg::immediateFormat) ? {1'b0, zRegister} :
        '0;

    assign IDaten =
        (format == dekoderPkg::jumpFormat) ? {6'b0, grosserImmediate} :
        (opcode == dekoderPkg::addisCode)  ? {kleinerImmediate, 16'b0} :
        (format[1] == dekoderPkg::immediateFormat && opcode > dekoderPkg::addisCode
            && opcode < dekoderPkg::loadCode) ? {16'b0, kleinerImmediate} :  // Logic ops
        (format[1] == dekoderPkg::immediateFormat) ?
            {{16{kleinerImmediate[15]}}, kleinerImmediate} :
        '0;

    assign ImmediateAktiv = (format == dekoderPkg::jumpFormat)
                         || (format[1] == dekoderPkg::immediateFormat);

    assign FunktionsCode =
        (format == dekoderPkg::registerFormat) ? funktion :
        (opcode == dekoderPkg::addisCode || format == dekoderPkg::jumpFormat
            || opcode >= dekoderPkg::loadCode) ? 6'b0 :
        {1'b0, funktionAnfang};

    assign JALBefehl       = (opcode == dekoderPkg::jalCode);
    assign AbsoluterSprung = (opcode == dekoderPkg::jregCode);
    assign LoadBefehl      = (opcode == dekoderPkg::loadCode || opcode == dekoderPkg::loadSCode);
    assign StoreBefehl     = (opcode == dekoderPkg::storeCode || opcode == dekoderPkg::storeSCode);
    assign Sprungbedingung = (opcode == dekoderPkg::bezCode);   // High means branch on zero

    assign BedingterSprungBefehl = (opcode == dekoderPkg::bezCode)
                                || (opcode == dekoderPkg::bnezCode);

    assign UnbedingterSprungBefehl = (opcode == dekoderPkg::jregCode)
                                  || (opcode == dekoderPkg::jalCode)
                                  || (opcode == dekoderPkg::jmpCode);

    assign RelativerSprung = (opcode == dekoderPkg::jalCode) || (opcode == dekoderPkg::jmpCode)
                          || BedingterSprungBefehl;

    keinLoadUndStore: assert property (
        @(posedge Reset) disable iff (DekodierSignal)
        !(LoadBefehl && StoreBefehl)
    );

endmodule

// File: ablaufSteuerung.sv
`timescale 1ns/1ps

module ablaufSteuerung (
    input  logic Reset,
    input  logic DekodierSignal,
    input  logic laufen,
    output logic holeStrobe,
    output logic dekodierStrobe,
    output logic ausfuehrStrobe
);

    dekoderPkg::ablaufZustand zustand;

    always_ff @(posedge Reset or posedge DekodierSignal) begin
        if (DekodierSignal) begin
            zustand <= dekoderPkg::ruhe;
        end else begin
            case (zustand)
                dekoderPkg::holen:      zustand <= dekoderPkg::dekodieren;
                dekoderPkg::dekodieren: zustand <= dekoderPkg::ausfuehren;
                default: begin
                    // Current instruction always finishes before stopping
                    zustand <= laufen ? dekoderPkg::holen : dekoderPkg::ruhe;
                end
            endcase
        end
    end

    assign holeStrobe     = (zustand == dekoderPkg::holen);
    assign dekodierStrobe = (zustand == dekoderPkg::dekodieren);
    assign ausfuehrStrobe = (zustand == dekoderPkg::ausfuehren);

    strobesEinzeln: assert property (
        @(posedge Reset) disable iff (DekodierSignal)
        $onehot0({holeStrobe, dekodierStrobe, ausfuehrStrobe})
    );

    ausfuehrNachDekodieren: assert property (
        @(posedge Reset) disable iff (DekodierSignal)
        ausfuehrStrobe |-> $past(dekodierStrobe)
    );

endmodule

// File: befehlsZaehler.sv
`timescale 1ns/1ps

module befehlsZaehler (
    input  logic                              Reset,
    input  logic                              DekodierSignal,
    input  logic                              ausfuehrStrobe,
    input  logic [dekoderPkg::wortBreite-1:0] IDaten,
    input  logic [dekoderPkg::wortBreite-1:0] quellWert1,
    input  logic                              RelativerSprung,
    input  logic                              AbsoluterSprung,
    input  logic                              BedingterSprungBefehl,
    input  logic                              Sprungbedingung,
    output logic [dekoderPkg::wortBreite-1:0] programmZaehler,
    output logic [dekoderPkg::wortBreite-1:0] rueckAdresse,
    output logic                              sprungGenommen
);

    logic bedingungErfuellt;
    logic relativNehmen;

    // bez tests for zero, bnez for nonzero
    assign bedingungErfuellt = Sprungbedingung ? (quellWert1 == '0) : (quellWert1 != '0);
    assign relativNehmen     = RelativerSprung && (!BedingterSprungBefehl || bedingungErfuellt);

    assign sprungGenommen = relativNehmen || AbsoluterSprung;
    assign rueckAdresse   = programmZaehler + 32'd4;

    always_ff @(posedge Reset or posedge DekodierSignal) begin
        if (DekodierSignal) begin
            programmZaehler <= '0;
        end else if (ausfuehrStrobe) begin
            if (relativNehmen) begin
                programmZaehler <= programmZaehler + IDaten;
            end else if (AbsoluterSprung) begin
                programmZaehler <= quellWert1;   // jreg
            end else begin
                programmZaehler <= rueckAdresse;
            end
        end
    end

    zaehlerAusgerichtet: assert property (
        @(posedge Reset) disable iff (DekodierSignal)
        ausfuehrStrobe |=> (programmZaehler[1:0] == 2'b00)
    );

endmodule

// File: registerBank.sv
`timescale 1ns/1ps

module registerBank (
    input  logic                                Reset,
    input  logic                                DekodierSignal,
    input  logic [dekoderPkg::regAdrBreite-1:0] leseAdresse1,
    input  logic [dekoderPkg::regAdrBreite-1:0] leseAdresse2,
    input  logic                                schreiben,
    input  logic [dekoderPkg::regAdrBreite-1:0] schreibAdresse,
    input  logic [dekoderPkg::wortBreite-1:0]   schreibDaten,
    output logic [dekoderPkg::wortBreite-1:0]   leseWert1,
    output logic [dekoderPkg::wortBreite-1:0]   leseWert2
);

    // Integer bank 0..31, float bank 32..63
    logic [dekoderPkg::wortBreite-1:0] register [2**dekoderPkg::regAdrBreite];

    always_ff @(posedge Reset or posedge DekodierSignal) begin
        if (DekodierSignal) begin
            for (int i = 0; i < 2**dekoderPkg::regAdrBreite; i++) begin
                register[i] <= '0;
            end
        end else if (schreiben) begin
            register[schreibAdresse] <= schreibDaten;
        end
    end

    assign leseWert1 = register[leseAdresse1];
    assign leseWert2 = register[leseAdresse2];

endmodule

// File: prozessorFrontend.sv
`timescale 1ns/1ps

module prozessorFrontend (
    input  logic                                         Reset,
    input  logic                                         DekodierSignal,
    input  logic                                         laufen,
    input  logic                                         ladeEnable,
    input  logic [$clog2(dekoderPkg::speicherTiefe)-1:0] ladeAdresse,
    input  logic [dekoderPkg::wortBreite-1:0]            ladeDaten,
    input  logic                                         debugSchreiben,
    input  logic [dekoderPkg::regAdrBreite-1:0]          debugAdresse,
    input  logic [dekoderPkg::wortBreite-1:0]            debugDaten,
    output logic                                         ausfuehrGueltig,
    output logic [dekoderPkg::wortBreite-1:0]            programmZaehler,
    output logic                                         sprungGenommen,
    output logic [dekoderPkg::regAdrBreite-1:0]          QuellRegister1,
    output logic [dekoderPkg::regAdrBreite-1:0]          QuellRegister2,
    output logic [dekoderPkg::regAdrBreite-1:0]          ZielRegister,
    output logic [dekoderPkg::wortBreite-1:0]            IDaten,
    output logic [5:0]                                   FunktionsCode,
    output logic                                         ImmediateAktiv,
    output logic                                         LoadBefehl,
    output logic                                         StoreBefehl,
    output logic                                         JALBefehl,
    output logic [dekoderPkg::wortBreite-1:0]            leseWert2
);

    logic                              holeStrobe;
    logic                              dekodierStrobe;
    logic [dekoderPkg::wortBreite-1:0] befehl;
    logic [dekoderPkg::wortBreite-1:0] quellWert1;
    logic [dekoderPkg::wortBreite-1:0] rueckAdresse;
    logic RelativerSprung;
    logic AbsoluterSprung;
    logic BedingterSprungBefehl;
    logic Sprungbedingung;
    logic linkSchreiben;
    logic debugAktiv;

    // Link write owns the port during execute, debug writes are dropped then
    assign linkSchreiben = ausfuehrGueltig && JALBefehl;
    assign debugAktiv    = debugSchreiben && !ausfuehrGueltig;

    ablaufSteuerung steuerung (
        .Reset          (Reset),
        .DekodierSignal (DekodierSignal),
        .laufen         (laufen),
        .holeStrobe     (holeStrobe),
        .dekodierStrobe (dekodierStrobe),
        .ausfuehrStrobe (ausfuehrGueltig)
    );

    befehlsSpeicher speicher (
        .Reset          (Reset),
        .ladeEnable     (ladeEnable),
        .ladeAdresse    (ladeAdresse),
        .ladeDaten      (ladeDaten),
        .holeStrobe     (holeStrobe),
        .befehlsAdresse (programmZaehler[$clog2(dekoderPkg::speicherTiefe)+1:2]),
        .befehl         (befehl)
    );

    instruktionsDekodierer dekodierer (
        .Reset                   (Reset),
        .DekodierSignal          (DekodierSignal),
        .dekodierStrobe          (dekodierStrobe),
        .Instruktion             (befehl),
        .QuellRegister1          (QuellRegister1),
        .QuellRegister2          (QuellRegister2),
        .ZielRegister            (ZielRegister),
        .IDaten                  (IDaten),
        .ImmediateAktiv          (ImmediateAktiv),
        .FunktionsCode           (FunktionsCode),
        .JALBefehl               (JALBefehl),
        .RelativerSprung         (RelativerSprung),
        .LoadBefehl              (LoadBefehl),
        .StoreBefehl             (StoreBefehl),
        .UnbedingterSprungBefehl (),
        .BedingterSprungBefehl   (BedingterSprungBefehl),
        .AbsoluterSprung         (AbsoluterSprung),
        .Sprungbedingung         (Sprungbedingung)
    );

    befehlsZaehler zaehler (
        .Reset                 (Reset),
        .DekodierSignal        (DekodierSignal),
        .ausfuehrStrobe        (ausfuehrGueltig),
        .IDaten                (IDaten),
        .quellWert1            (quellWert1),
        .RelativerSprung       (RelativerSprung),
        .AbsoluterSprung       (AbsoluterSprung),
        .BedingterSprungBefehl (BedingterSprungBefehl),
        .Sprungbedingung       (Sprungbedingung),
        .programmZaehler       (programmZaehler),
        .rueckAdresse          (rueckAdresse),
        .sprungGenommen        (sprungGenommen)
    );

    registerBank register (
        .Reset          (Reset),
        .DekodierSignal (DekodierSignal),
        .leseAdresse1   (QuellRegister1),
        .leseAdresse2   (QuellRegister2),
        .schreiben      (linkSchreiben || debugAktiv),
        .schreibAdresse (linkSchreiben ? dekoderPkg::linkRegister : debugAdresse),
        .schreibDaten   (linkSchreiben ? rueckAdresse : debugDaten),
        .leseWert1      (quellWert1),
        .leseWert2      (leseWert2)
    );

endmodule

// File: ausfuehrMonitor.sv
`timescale 1ns/1ps

module ausfuehrMonitor (
    input  logic                                         Reset,
    input  logic                                         DekodierSignal,
    input  logic                                         ladeEnable,
    input  logic [$clog2(dekoderPkg::speicherTiefe)-1:0] ladeAdresse,
    input  logic [31:0]                                  ladeDaten,
    input  logic                                         debugSchreiben,
    input  logic [5:0]                                   debugAdresse,
    input  logic [31:0]                                  debugDaten,
    input  logic                                         ausfuehrGueltig,
    input  logic [31:0]                                  programmZaehler,
    input  logic                                         sprungGenommen,
    input  logic [5:0]                                   QuellRegister1,
    input  logic [5:0]                                   QuellRegister2,
    input  logic [5:0]                                   ZielRegister,
    input  logic [31:0]                                  IDaten,
    input  logic [5:0]                                   FunktionsCode,
    input  logic                                         ImmediateAktiv,
    input  logic                                         LoadBefehl,
    input  logic                                         StoreBefehl,
    input  logic                                         JALBefehl,
    input  logic [31:0]                                  leseWert2,
    output int                                           pruefungen,
    output int                                           fehler,
    output int                                           ausfuehrungen
);

    logic [31:0] programm [dekoderPkg::speicherTiefe];
    logic [31:0] schatten [64];   // Shadow of the register file
    logic [31:0] pcErwartet;

    logic [5:0]  q1;
    logic [5:0]  q2;
    logic [5:0]  zr;
    logic [31:0] imm;
    logic        immAkt;
    logic [5:0]  funkt;
    logic        ld;
    logic        st;
    logic        jal;
    logic [31:0] naechster;
    logic        genommen;

    initial begin
        pruefungen    = 0;
        fehler        = 0;
        ausfuehrungen = 0;
    end

    // Expected decode and next counter, built from the field rules
    function automatic void referenz(input logic [31:0] b, input logic [31:0] pc);
        logic [5:0]  op;
        logic        fb;
        logic [31:0] w1;
        logic        rel;
        logic        ok;
        op = b[31:26];
        fb = (op[5:4] == 2'b00) && (b[5:4] == 2'b10);
        q1 = {fb, b[20:16]};
        if (op == dekoderPkg::storeCode) q2 = {1'b0, b[25:21]};
        else if (op == dekoderPkg::storeSCode) q2 = {1'b1, b[25:21]};
        else q2 = {fb, b[15:11]};
        if (op == dekoderPkg::loadSCode || op == dekoderPkg::storeSCode || (fb && !b[3]))
            zr = {1'b1, b[25:21]};
        else if (op[5:4] != 2'b01) zr = {1'b0, b[25:21]};
        else zr = 6'd0;
        if (op[5:4] == 2'b01) imm = {6'd0, b[25:0]};
        else if (op == dekoderPkg::addisCode) imm = {b[15:0], 16'd0};
        else if (op[5] && op > dekoderPkg::addisCode && op < dekoderPkg::loadCode)
            imm = {16'd0, b[15:0]};
        else if (op[5]) imm = {{16{b[15]}}, b[15:0]};
        else imm = 32'd0;
        immAkt = op[5] || (op[5:4] == 2'b01);
        if (op[5:4] == 2'b00) funkt = b[5:0];
        else if (op == dekoderPkg::addisCode || op[5:4] == 2'b01 || op >= dekoderPkg::loadCode)
            funkt = 6'd0;
        else funkt = {1'b0, op[4:0]};
        ld  = (op == dekoderPkg::loadCode) || (op == dekoderPkg::loadSCode);
        st  = (op == dekoderPkg::storeCode) || (op == dekoderPkg::storeSCode);
        jal = (op == dekoderPkg::jalCode);
        w1  = schatten[q1];
        rel = jal || op == dekoderPkg::jmpCode || op == dekoderPkg::bezCode
            || op == dekoderPkg::bnezCode;
        ok  = (op == dekoderPkg::bezCode)  ? (w1 == 32'd0) :
              (op == dekoderPkg::bnezCode) ? (w1 != 32'd0) : 1'b1;
        if (rel && ok) begin
            naechster = pc + imm;
            genommen  = 1'b1;
        end else if (op == dekoderPkg::jregCode) begin
            naechster = w1;
            genommen  = 1'b1;
        end else begin
            naechster = pc + 32'd4;
            genommen  = 1'b0;
        end
    endfunction

    task automatic pruefe(input string feld, input logic [31:0] ist, input logic [31:0] soll);
        pruefungen++;
        if (ist !== soll) begin
            fehler++;
            $display("[FAIL] %0d ns: %s at pc %h is %h, expected %h",
                     $time, feld, pcErwartet, ist, soll);
        end
    endtask

    always @(posedge Reset or posedge DekodierSignal) begin
        if (DekodierSignal) begin
            for (int i = 0; i < 64; i++) begin
                schatten[i] <= 32'd0;
            end
            pcErwartet <= 32'd0;
        end else begin
            if (ladeEnable) begin
                programm[ladeAdresse] <= ladeDaten;
            end
            if (ausfuehrGueltig) begin
                ausfuehrungen++;
                referenz(programm[pcErwartet[7:2]], pcErwartet);
                pruefe("programmZaehler", programmZaehler, pcErwartet);
                pruefe("QuellRegister1", {26'd0, QuellRegister1}, {26'd0, q1});
                pruefe("QuellRegister2", {26'd0, QuellRegister2}, {26'd0, q2});
                pruefe("ZielRegister", {26'd0, ZielRegister}, {26'd0, zr});
                pruefe("IDaten", IDaten, imm);
                pruefe("FunktionsCode", {26'd0, FunktionsCode}, {26'd0, funkt});
                pruefe("ImmediateAktiv", {31'd0, ImmediateAktiv}, {31'd0, immAkt});
                pruefe("LoadBefehl", {31'd0, LoadBefehl}, {31'd0, ld});
                pruefe("StoreBefehl", {31'd0, StoreBefehl}, {31'd0, st});
                pruefe("JALBefehl", {31'd0, JALBefehl}, {31'd0, jal});
                pruefe("sprungGenommen", {31'd0, sprungGenommen}, {31'd0, genommen});
                pruefe("leseWert2", leseWert2, schatten[q2]);
                if (jal) begin
                    schatten[31] <= pcErwartet + 32'd4;   // Link write
                end
                pcErwartet <= naechster;
            end else if (debugSchreiben) begin
                schatten[debugAdresse] <= debugDaten;
            end
        end
    end

endmodule

// File: prozessorFrontendTb.sv
`timescale 1ns/1ps

module prozessorFrontendTb;

    localparam int befehleGesamt  = 25;
    localparam int zyklenGrenze   = 3 * befehleGesamt + 200;

    logic        Reset = 1'b0;
    logic        DekodierSignal = 1'b1;
    logic        laufen = 1'b0;
    logic        ladeEnable = 1'b0;
    logic [5:0]  ladeAdresse = 6'd0;
    logic [31:0] ladeDaten = 32'd0;
    logic        debugSchreiben = 1'b0;
    logic [5:0]  debugAdresse = 6'd0;
    logic [31:0] debugDaten = 32'd0;

    logic        ausfuehrGueltig;
    logic [31:0] programmZaehler;
    logic        sprungGenommen;
    logic [5:0]  QuellRegister1;
    logic [5:0]  QuellRegister2;
    logic [5:0]  ZielRegister;
    logic [31:0] IDaten;
    logic [5:0]  FunktionsCode;
    logic        ImmediateAktiv;
    logic        LoadBefehl;
    logic        StoreBefehl;
    logic        JALBefehl;
    logic [31:0] leseWert2;

    int pruefungen;
    int fehler;
    int ausfuehrungen;
    int zyklen = 0;
    int bestanden = 0;
    int durchgefallen = 0;
    int zusatzFehler = 0;
    int fehlerVorher = 0;
    integer seed = 92785;
    logic [31:0] zufall;

    always #10 Reset = ~Reset;

    prozessorFrontend UUT (.*);

    ausfuehrMonitor monitor (.*);

    always @(posedge Reset) begin
        zyklen++;
        if (zyklen > zyklenGrenze) begin
            $display("Run did not finish within %0d cycles", zyklenGrenze);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] regBefehl(input logic [5:0] funkt, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {6'b000000, rd, rs1, rs2, 5'd0, funkt};
    endfunction

    function automatic logic [31:0] immBefehl(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [15:0] wert);
        return {op, rd, rs1, wert};
    endfunction

    task automatic resetDut();
        @(negedge Reset);
        DekodierSignal = 1'b1;
        repeat (10) @(negedge Reset);
        DekodierSignal = 1'b0;
    endtask

    task automatic ladeWort(input logic [5:0] adresse, input logic [31:0] wort);
        @(negedge Reset);
        ladeEnable  = 1'b1;
        ladeAdresse = adresse;
        ladeDaten   = wort;
        @(negedge Reset);
        ladeEnable = 1'b0;
    endtask

    task automatic registerSetzen(input logic [5:0] adresse, input logic [31:0] wert);
        @(negedge Reset);
        debugSchreiben = 1'b1;
        debugAdresse   = adresse;
        debugDaten     = wert;
        @(negedge Reset);
        debugSchreiben = 1'b0;
    endtask

    // Lowers laufen during the n-th execute pulse
    task automatic ausfuehren(input int n);
        int k;
        k = 0;
        laufen = 1'b1;
        while (k < n) begin
            @(negedge Reset);
            if (ausfuehrGueltig) k++;
        end
        laufen = 1'b0;
        @(negedge Reset);
    endtask

    task automatic testEnde(input string name);
        int neu;
        neu = fehler - fehlerVorher + zusatzFehler;
        if (neu == 0) begin
            bestanden++;
            $display("Test %s: passed", name);
        end else begin
            durchgefallen++;
            $display("Test %s: failed with %0d errors", name, neu);
        end
        fehlerVorher = fehler;
        zusatzFehler = 0;
    endtask

    initial begin
        int pulse;
        // Straight-line register and immediate instructions
        resetDut();
        ladeWort(0, regBefehl(6'h01, 5'd3, 5'd1, 5'd2));
        ladeWort(1, regBefehl(6'h23, 5'd4, 5'd5, 5'd6));   // Float, upper target bank
        ladeWort(2, regBefehl(6'h2A, 5'd7, 5'd8, 5'd9));
        ladeWort(3, regBefehl(6'h31, 5'd10, 5'd11, 5'd12));
        zufall = $random(seed);
        ladeWort(4, immBefehl(dekoderPkg::addisCode, 5'd4, 5'd0, zufall[15:0]));
        zufall = $random(seed);
        ladeWort(5, immBefehl(6'b110100, 5'd5, 5'd2, zufall[15:0] | 16'h8000));
        zufall = $random(seed);
        ladeWort(6, immBefehl(6'b100010, 5'd6, 5'd3, zufall[15:0] | 16'h8000));
        registerSetzen(6'd2, $random(seed));
        registerSetzen(6'd38, $random(seed));
        ausfuehren(7);
        testEnde("straight line");

        resetDut();
        ladeWort(0, immBefehl(dekoderPkg::loadCode, 5'd5, 5'd1, 16'h0010));
        ladeWort(1, immBefehl(dekoderPkg::loadSCode, 5'd6, 5'd2, 16'hFFF0));
        ladeWort(2, immBefehl(dekoderPkg::storeCode, 5'd7, 5'd3, 16'h0004));
        ladeWort(3, immBefehl(dekoderPkg::storeSCode, 5'd9, 5'd4, 16'h8000));
        registerSetzen(6'd7, $random(seed));
        registerSetzen(6'd41, $random(seed));
        ausfuehren(4);
        testEnde("load store");

        resetDut();
        ladeWort(0, {dekoderPkg::jmpCode, 26'd8});
        ladeWort(1, regBefehl(6'h01, 5'd1, 5'd1, 5'd1));
        ladeWort(2, {dekoderPkg::jalCode, 26'd8});
        ladeWort(3, regBefehl(6'h01, 5'd1, 5'd1, 5'd1));
        ladeWort(4, immBefehl(dekoderPkg::storeCode, 5'd31, 5'd0, 16'd0));   // Reads link
        ausfuehren(3);
        testEnde("jmp jal");

        resetDut();
        ladeWort(0, immBefehl(dekoderPkg::bezCode, 5'd0, 5'd1, 16'd8));
        ladeWort(2, immBefehl(dekoderPkg::bezCode, 5'd0, 5'd2, 16'd8));
        ladeWort(3, immBefehl(dekoderPkg::bnezCode, 5'd0, 5'd2, 16'd8));
        ladeWort(5, immBefehl(dekoderPkg::bnezCode, 5'd0, 5'd1, 16'd8));
        registerSetzen(6'd1, 32'd0);
        registerSetzen(6'd2, $random(seed) | 32'd1);
        ausfuehren(4);
        testEnde("branches");

        resetDut();
        ladeWort(0, immBefehl(dekoderPkg::jregCode, 5'd0, 5'd6, 16'd0));
        ladeWort(4, regBefehl(6'h01, 5'd2, 5'd6, 5'd6));
        registerSetzen(6'd6, 32'd16);
        ausfuehren(2);
        testEnde("jump register");

        resetDut();
        for (int i = 0; i < 6; i++) begin
            ladeWort(i[5:0], regBefehl(6'h02, i[4:0], 5'd1, 5'd2));
        end
        ausfuehren(2);
        pulse = 0;
        repeat (12) begin
            @(negedge Reset);
            if (ausfuehrGueltig) pulse++;
        end
        if (pulse != 0) begin
            zusatzFehler++;
            $display("Execute pulses continued after laufen was lowered");
        end
        ausfuehren(3);
        testEnde("pause resume");

        $display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d, executed %0d",
                 bestanden, durchgefallen, pruefungen, fehler, ausfuehrungen);
        if (durchgefallen == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
dekoderPkg.sv
befehlsSpeicher.sv
instruktionsDekodierer.sv
ablaufSteuerung.sv
befehlsZaehler.sv
registerBank.sv
prozessorFrontend.sv
ausfuehrMonitor.sv
prozessorFrontendTb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module prozessorFrontendTb -o simTb

ausgabe=$(./obj_dir/simTb)
echo "$ausgabe"

if echo "$ausgabe" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
